//--- verilog/log_replay_defines.svh
`ifndef LOG_REPLAY_DEFINES_SVH
`define LOG_REPLAY_DEFINES_SVH

// Log depth as a power of two.
`define LOG_ENTRIES_LOG_2 4
`define LOG_ENTRIES (1 << `LOG_ENTRIES_LOG_2)
`define LOG_ADDR_W `LOG_ENTRIES_LOG_2

// Wide forward and response width.
`define NOC_DATA_WIDTH 64

// Narrow flit width on the read channel.
`define NOC_NARROW_W 32

`define LOG_SEQ_W 32

`endif

//--- verilog/log_noc_pkg.sv
`default_nettype none

`include "log_replay_defines.svh"

package log_noc_pkg;

    // Opcode sits in the top byte of a wide request.
    localparam int LOG_OP_W = 8;
    localparam int LOG_REQ_OP_LO = `NOC_DATA_WIDTH - LOG_OP_W;

    // Address is in the low LOG_ADDR_W bits.
    typedef enum logic [LOG_OP_W-1:0] {
        LOG_OP_READ_ENTRY = 8'd1,
        LOG_OP_READ_TAIL  = 8'd2
    } log_rd_op_e;

    // Returned for an unknown opcode.
    localparam logic [`NOC_DATA_WIDTH-1:0] LOG_RESP_BAD_OP = '1;

endpackage

`default_nettype wire

//--- verilog/log_entry_pkg.sv
`default_nettype none

`include "log_replay_defines.svh"

package log_entry_pkg;

    localparam int LOG_DATA_LO_W = `NOC_DATA_WIDTH / 2;

    // Sequence number in the high half.
    typedef struct packed {
        logic [`LOG_SEQ_W-1:0]    seq;
        logic [LOG_DATA_LO_W-1:0] data_lo;
    } log_entry_t;

    localparam int LOG_ENTRY_W = $bits(log_entry_t);

    typedef enum logic [1:0] {
        RD_IDLE, RD_MEM_REQ, RD_MEM_RESP, RD_SEND
    } log_rd_state_e;

endpackage

`default_nettype wire

//--- verilog/noc_narrow_to_wide.sv
`default_nettype none
`timescale 1ns/1ps

`include "log_replay_defines.svh"

module noc_narrow_to_wide (
     input  logic                           clk
    ,input  logic                           arst_n

    ,input  logic                           src_val
    ,input  logic   [`NOC_NARROW_W-1:0]     src_data
    ,output logic                           src_rdy

    ,output logic                           dst_val
    ,output logic   [`NOC_DATA_WIDTH-1:0]   dst_data
    ,input  logic                           dst_rdy
);

    logic                           flit_cnt;
    logic                           full;
    logic   [`NOC_DATA_WIDTH-1:0]   data_q;

    // Stall the narrow side while a wide word waits.
    assign src_rdy  = ~full;
    assign dst_val  = full;
    assign dst_data = data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flit_cnt <= 1'b0;
            full     <= 1'b0;
        end else if (src_val && src_rdy) begin
            flit_cnt <= ~flit_cnt;
            full     <= flit_cnt;
        end else if (dst_val && dst_rdy) begin
            full <= 1'b0;
        end
    end

    // High flit first.
    always_ff @(posedge clk) begin
        if (src_val && src_rdy) begin
            if (!flit_cnt) begin
                data_q[`NOC_DATA_WIDTH-1:`NOC_NARROW_W] <= src_data;
            end else begin
                data_q[`NOC_NARROW_W-1:0] <= src_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/noc_wide_to_narrow.sv
`default_nettype none
`timescale 1ns/1ps

`include "log_replay_defines.svh"

module noc_wide_to_narrow (
     input  logic                           clk
    ,input  logic                           arst_n

    ,input  logic                           src_val
    ,input  logic   [`NOC_DATA_WIDTH-1:0]   src_data
    ,output logic                           src_rdy

    ,output logic                           dst_val
    ,output logic   [`NOC_NARROW_W-1:0]     dst_data
    ,input  logic                           dst_rdy
);

    logic                           full;
    logic                           half_sel;
    logic   [`NOC_DATA_WIDTH-1:0]   data_q;

    assign src_rdy  = ~full;
    assign dst_val  = full;
    assign dst_data = half_sel ? data_q[`NOC_NARROW_W-1:0]
                               : data_q[`NOC_DATA_WIDTH-1:`NOC_NARROW_W];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full     <= 1'b0;
            half_sel <= 1'b0;
        end else if (src_val && src_rdy) begin
            full     <= 1'b1;
            half_sel <= 1'b0;
        end else if (dst_val && dst_rdy) begin
            // Free after the low half goes out.
            full     <= ~half_sel;
            half_sel <= ~half_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (src_val && src_rdy) begin
            data_q <= src_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/log_recorder.sv
`default_nettype none
`timescale 1ns/1ps

`include "log_replay_defines.svh"

module log_recorder import log_entry_pkg::*; (
     input  logic                           clk
    ,input  logic                           arst_n

    ,input  logic                           fwd_val
    ,input  logic                           fwd_rdy
    ,input  logic   [`NOC_DATA_WIDTH-1:0]   fwd_data

    ,output logic                           wr_val
    ,output logic   [`LOG_ADDR_W-1:0]       wr_addr
    ,output log_entry_t                     wr_entry

    ,output logic   [`LOG_ADDR_W-1:0]       tail_addr
);

    logic                           fwd_fire;
    logic   [`LOG_ADDR_W-1:0]       tail_q;
    logic   [`LOG_SEQ_W-1:0]        seq_q;

    // Snoop only, never drives the forward ready.
    assign fwd_fire  = fwd_val & fwd_rdy;
    assign tail_addr = tail_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_val <= 1'b0;
            tail_q <= '0;
            seq_q  <= '0;
        end else begin
            wr_val <= fwd_fire;
            if (fwd_fire) begin
                tail_q <= tail_q + 1'b1;
                seq_q  <= seq_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_fire) begin
            wr_addr          <= tail_q;
            wr_entry.seq     <= seq_q;
            wr_entry.data_lo <= fwd_data[LOG_DATA_LO_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- verilog/log_ram.sv
`default_nettype none
`timescale 1ns/1ps

`include "log_replay_defines.svh"

module log_ram import log_entry_pkg::*; (
     input  logic                       clk
    ,input  logic                       arst_n

    ,input  logic                       wr_val
    ,input  logic   [`LOG_ADDR_W-1:0]   wr_addr
    ,input  log_entry_t                 wr_entry

    ,input  logic                       rd_req_val
    ,input  logic   [`LOG_ADDR_W-1:0]   rd_req_addr
    ,output logic                       rd_req_rdy

    ,output logic                       rd_resp_val
    ,output log_entry_t                 rd_resp_entry
    ,input  logic                       rd_resp_rdy
);

    logic   [LOG_ENTRY_W-1:0]   mem [`LOG_ENTRIES];
    logic                       rd_fire;

    // Accept when the response slot is empty or draining.
    assign rd_req_rdy = ~rd_resp_val | rd_resp_rdy;
    assign rd_fire    = rd_req_val & rd_req_rdy;

    always_ff @(posedge clk) begin
        if (wr_val) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_resp_val <= 1'b0;
        end else if (rd_fire) begin
            rd_resp_val <= 1'b1;
        end else if (rd_resp_rdy) begin
            rd_resp_val <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_resp_entry <= mem[rd_req_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/log_read_engine.sv
`default_nettype none
`timescale 1ns/1ps

`include "log_replay_defines.svh"

module log_read_engine import log_noc_pkg::*, log_entry_pkg::*; (
     input  logic                           clk
    ,input  logic                           arst_n

    ,input  logic                           req_val
    ,input  logic   [`NOC_DATA_WIDTH-1:0]   req_data
    ,output logic                           req_rdy

    ,output logic                           resp_val
    ,output logic   [`NOC_DATA_WIDTH-1:0]   resp_data
    ,input  logic                           resp_rdy

    ,output logic                           mem_req_val
    ,output logic   [`LOG_ADDR_W-1:0]       mem_req_addr
    ,input  logic                           mem_req_rdy

    ,input  logic                           mem_resp_val
    ,input  log_entry_t                     mem_resp_entry
    ,output logic                           mem_resp_rdy

    ,input  logic   [`LOG_ADDR_W-1:0]       tail_addr
);

    log_rd_state_e                  state;
    log_rd_op_e                     req_op;
    logic   [`LOG_ADDR_W-1:0]       addr_q;
    logic   [`NOC_DATA_WIDTH-1:0]   resp_q;

    assign req_op = log_rd_op_e'(req_data[`NOC_DATA_WIDTH-1:LOG_REQ_OP_LO]);

    assign req_rdy      = (state == RD_IDLE);
    assign mem_req_val  = (state == RD_MEM_REQ);
    assign mem_req_addr = addr_q;
    assign mem_resp_rdy = (state == RD_MEM_RESP);
    assign resp_val     = (state == RD_SEND);
    assign resp_data    = resp_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (req_val) begin
                        state <= (req_op == LOG_OP_READ_ENTRY) ? RD_MEM_REQ : RD_SEND;
                    end
                end
                RD_MEM_REQ: begin
                    if (mem_req_rdy) begin
                        state <= RD_MEM_RESP;
                    end
                end
                RD_MEM_RESP: begin
                    if (mem_resp_val) begin
                        state <= RD_SEND;
                    end
                end
                RD_SEND: begin
                    if (resp_rdy) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Response word, built on accept or on the memory return.
    always_ff @(posedge clk) begin
        if (req_val && req_rdy) begin
            addr_q <= req_data[`LOG_ADDR_W-1:0];
            case (req_op)
                LOG_OP_READ_ENTRY: resp_q <= resp_q;
                LOG_OP_READ_TAIL:  resp_q <= {{(`NOC_DATA_WIDTH-`LOG_ADDR_W){1'b0}}, tail_addr};
                default:           resp_q <= LOG_RESP_BAD_OP;
            endcase
        end else if (mem_resp_val && mem_resp_rdy) begin
            resp_q <= {mem_resp_entry.seq, mem_resp_entry.data_lo};
        end
    end

endmodule

`default_nettype wire

//--- verilog/tcp_log_replay.sv
`default_nettype none
`timescale 1ns/1ps

`include "log_replay_defines.svh"

module tcp_log_replay import log_entry_pkg::*; (
     input  logic                           clk
    ,input  logic                           arst_n

    ,input  logic                           inject_val
    ,input  logic   [`NOC_DATA_WIDTH-1:0]   inject_data
    ,output logic                           inject_rdy

    ,output logic                           noc0_val
    ,output logic   [`NOC_DATA_WIDTH-1:0]   noc0_data
    ,input  logic                           noc0_rdy

    ,input  logic                           rd_req_val
    ,input  logic   [`NOC_NARROW_W-1:0]     rd_req_data
    ,output logic                           rd_req_rdy

    ,output logic                           rd_resp_val
    ,output logic   [`NOC_NARROW_W-1:0]     rd_resp_data
    ,input  logic                           rd_resp_rdy
);

    logic                           wr_logger_mem_val;
    logic   [`LOG_ADDR_W-1:0]       wr_logger_mem_addr;
    log_entry_t                     wr_logger_mem_entry;
    logic   [`LOG_ADDR_W-1:0]       recorder_tail_addr;

    logic                           rd_req_logger_mem_val;
    logic   [`LOG_ADDR_W-1:0]       rd_req_logger_mem_addr;
    logic                           rd_req_logger_mem_rdy;
    logic                           rd_resp_logger_mem_val;
    log_entry_t                     rd_resp_logger_mem_entry;
    logic                           rd_resp_logger_mem_rdy;

    logic                           ctd_logger_read_val;
    logic   [`NOC_DATA_WIDTH-1:0]   ctd_logger_read_data;
    logic                           logger_read_ctd_rdy;
    logic                           logger_read_dtc_val;
    logic   [`NOC_DATA_WIDTH-1:0]   logger_read_dtc_data;
    logic                           dtc_logger_read_rdy;

    // Forward path, zero latency.
    assign noc0_val   = inject_val;
    assign noc0_data  = inject_data;
    assign inject_rdy = noc0_rdy;

    noc_narrow_to_wide ctd (
         .clk(clk), .arst_n(arst_n)
        ,.src_val(rd_req_val), .src_data(rd_req_data), .src_rdy(rd_req_rdy)
        ,.dst_val(ctd_logger_read_val), .dst_data(ctd_logger_read_data)
        ,.dst_rdy(logger_read_ctd_rdy)
    );

    log_read_engine logger_read (
         .clk(clk), .arst_n(arst_n)
        ,.req_val(ctd_logger_read_val), .req_data(ctd_logger_read_data)
        ,.req_rdy(logger_read_ctd_rdy)
        ,.resp_val(logger_read_dtc_val), .resp_data(logger_read_dtc_data)
        ,.resp_rdy(dtc_logger_read_rdy)
        ,.mem_req_val(rd_req_logger_mem_val), .mem_req_addr(rd_req_logger_mem_addr)
        ,.mem_req_rdy(rd_req_logger_mem_rdy)
        ,.mem_resp_val(rd_resp_logger_mem_val), .mem_resp_entry(rd_resp_logger_mem_entry)
        ,.mem_resp_rdy(rd_resp_logger_mem_rdy)
        ,.tail_addr(recorder_tail_addr)
    );

    noc_wide_to_narrow dtc (
         .clk(clk), .arst_n(arst_n)
        ,.src_val(logger_read_dtc_val), .src_data(logger_read_dtc_data)
        ,.src_rdy(dtc_logger_read_rdy)
        ,.dst_val(rd_resp_val), .dst_data(rd_resp_data), .dst_rdy(rd_resp_rdy)
    );

    log_recorder recorder (
         .clk(clk), .arst_n(arst_n)
        ,.fwd_val(inject_val), .fwd_rdy(noc0_rdy), .fwd_data(inject_data)
        ,.wr_val(wr_logger_mem_val), .wr_addr(wr_logger_mem_addr)
        ,.wr_entry(wr_logger_mem_entry)
        ,.tail_addr(recorder_tail_addr)
    );

    log_ram ram (
         .clk(clk), .arst_n(arst_n)
        ,.wr_val(wr_logger_mem_val), .wr_addr(wr_logger_mem_addr)
        ,.wr_entry(wr_logger_mem_entry)
        ,.rd_req_val(rd_req_logger_mem_val), .rd_req_addr(rd_req_logger_mem_addr)
        ,.rd_req_rdy(rd_req_logger_mem_rdy)
        ,.rd_resp_val(rd_resp_logger_mem_val), .rd_resp_entry(rd_resp_logger_mem_entry)
        ,.rd_resp_rdy(rd_resp_logger_mem_rdy)
    );

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen (
     output logic   clk
    ,output logic   arst_n
);

    // 40 ns period.
    localparam int HALF_PERIOD_NS = 20;
    localparam int RESET_CYCLES   = 2;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // Release on a falling edge, clear of the sampling edge.
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/tb_tcp_log_replay.sv
`default_nettype none
`timescale 1ns/1ps

`include "log_replay_defines.svh"

module tb_tcp_log_replay import log_noc_pkg::*, log_entry_pkg::*; ();

    localparam int CYCLES_PER_STEP = 40;
    localparam int CYCLE_MARGIN    = 200;

    // One table row, either a forward packet or a read request.
    typedef struct packed {
        logic                           is_read;
        logic   [`NOC_DATA_WIDTH-1:0]   fwd_data;
        logic   [3:0]                   stall;
        logic   [7:0]                   op;
        logic   [`LOG_ADDR_W-1:0]       addr;
        log_entry_t                     exp_entry;
    } step_t;

    logic                           clk;
    logic                           arst_n;
    logic                           inject_val;
    logic   [`NOC_DATA_WIDTH-1:0]   inject_data;
    logic                           inject_rdy;
    logic                           noc0_val;
    logic   [`NOC_DATA_WIDTH-1:0]   noc0_data;
    logic                           noc0_rdy;
    logic                           rd_req_val;
    logic   [`NOC_NARROW_W-1:0]     rd_req_data;
    logic                           rd_req_rdy;
    logic                           rd_resp_val;
    logic   [`NOC_NARROW_W-1:0]     rd_resp_data;
    logic                           rd_resp_rdy;

    step_t                          steps[$];
    log_entry_t                     model_mem [`LOG_ENTRIES];
    logic   [`LOG_SEQ_W-1:0]        model_seq;
    logic   [`LOG_ADDR_W-1:0]       model_tail;
    int                             cycle_count;
    int                             cycle_limit;

    tb_clkgen i_clkgen (
         .clk(clk)
        ,.arst_n(arst_n)
    );

    tcp_log_replay i_tcp_log_replay (
         .clk(clk), .arst_n(arst_n)
        ,.inject_val(inject_val), .inject_data(inject_data), .inject_rdy(inject_rdy)
        ,.noc0_val(noc0_val), .noc0_data(noc0_data), .noc0_rdy(noc0_rdy)
        ,.rd_req_val(rd_req_val), .rd_req_data(rd_req_data), .rd_req_rdy(rd_req_rdy)
        ,.rd_resp_val(rd_resp_val), .rd_resp_data(rd_resp_data), .rd_resp_rdy(rd_resp_rdy)
    );

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_fwd(input logic got_val, input logic [`NOC_DATA_WIDTH-1:0] got_data,
                             input logic got_rdy, input logic exp_rdy,
                             input logic [`NOC_DATA_WIDTH-1:0] exp_data);
        if (got_val !== 1'b1 || got_data !== exp_data || got_rdy !== exp_rdy) begin
            $display("[ERROR] %0t: noc0 %b %h inject_rdy %b, expected %h rdy %b",
                     $time, got_val, got_data, got_rdy, exp_data, exp_rdy);
            abort_run();
        end
    endtask

    task automatic check_entry(input log_entry_t got, input log_entry_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: response seq %h data_lo %h, expected seq %h data_lo %h",
                     $time, got.seq, got.data_lo, exp.seq, exp.data_lo);
            abort_run();
        end
    endtask

    // Reference log, same entry rule as the recorder.
    function automatic void add_fwd(input logic [`NOC_DATA_WIDTH-1:0] data, input int stall);
        step_t s;
        s          = '0;
        s.fwd_data = data;
        s.stall    = stall[3:0];
        steps.push_back(s);
        model_mem[model_tail].seq     = model_seq;
        model_mem[model_tail].data_lo = data[LOG_DATA_LO_W-1:0];
        // Wraps at 16 entries.
        model_tail++;
        model_seq++;
    endfunction

    function automatic void add_read(input logic [7:0] op, input logic [`LOG_ADDR_W-1:0] addr);
        step_t s;
        s         = '0;
        s.is_read = 1'b1;
        s.op      = op;
        s.addr    = addr;
        if (op == LOG_OP_READ_ENTRY) begin
            s.exp_entry = model_mem[addr];
        end else if (op == LOG_OP_READ_TAIL) begin
            s.exp_entry = {{(`NOC_DATA_WIDTH-`LOG_ADDR_W){1'b0}}, model_tail};
        end else begin
            s.exp_entry = '1;
        end
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        for (int i = 0; i < 5; i++) begin
            add_fwd({32'hf00d_0000 + i, $urandom}, i % 4);
        end
        for (int i = 0; i < 5; i++) begin
            add_read(LOG_OP_READ_ENTRY, i[`LOG_ADDR_W-1:0]);
        end
        add_read(LOG_OP_READ_TAIL, '0);
        // Past one full wrap of the log.
        for (int i = 5; i < 20; i++) begin
            add_fwd({32'hf00d_0000 + i, $urandom}, i % 3);
        end
        for (int i = 0; i < 4; i++) begin
            add_read(LOG_OP_READ_ENTRY, i[`LOG_ADDR_W-1:0]);
        end
        add_read(LOG_OP_READ_ENTRY, 4'd5);
        add_read(LOG_OP_READ_TAIL, '0);
        add_read(8'h7f, 4'd2);
        add_read(LOG_OP_READ_ENTRY, 4'd4);
        add_read(8'h00, 4'd0);
        add_read(LOG_OP_READ_TAIL, '0);
    endfunction

    task automatic send_fwd(input step_t s);
        @(negedge clk);
        inject_val  = 1'b1;
        inject_data = s.fwd_data;
        noc0_rdy    = 1'b0;
        repeat (s.stall) begin
            @(posedge clk);
            check_fwd(noc0_val, noc0_data, inject_rdy, 1'b0, s.fwd_data);
            @(negedge clk);
        end
        noc0_rdy = 1'b1;
        @(posedge clk);
        check_fwd(noc0_val, noc0_data, inject_rdy, 1'b1, s.fwd_data);
        @(negedge clk);
        inject_val  = 1'b0;
        inject_data = '0;
    endtask

    // Called on a falling edge, returns on one.
    task automatic send_flit(input logic [`NOC_NARROW_W-1:0] flit);
        int gap;
        gap        = $urandom % 3;
        rd_req_val = 1'b0;
        repeat (gap) @(negedge clk);
        rd_req_val  = 1'b1;
        rd_req_data = flit;
        while (!rd_req_rdy) @(negedge clk);
        @(negedge clk);
        rd_req_val = 1'b0;
    endtask

    task automatic recv_flit(output logic [`NOC_NARROW_W-1:0] flit);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            rd_resp_rdy = ($urandom % 4) != 0;
            if (rd_resp_val && rd_resp_rdy) begin
                flit  = rd_resp_data;
                taken = 1'b1;
            end
            @(negedge clk);
        end
        rd_resp_rdy = 1'b0;
    endtask

    task automatic send_read(input step_t s);
        logic   [`NOC_DATA_WIDTH-1:0]   req_word;
        logic   [`NOC_NARROW_W-1:0]     hi;
        logic   [`NOC_NARROW_W-1:0]     lo;
        req_word                           = '0;
        req_word[`NOC_DATA_WIDTH-1 -: 8]   = s.op;
        req_word[`LOG_ADDR_W-1:0]          = s.addr;
        @(negedge clk);
        send_flit(req_word[`NOC_DATA_WIDTH-1:`NOC_NARROW_W]);
        send_flit(req_word[`NOC_NARROW_W-1:0]);
        // High flit comes first.
        recv_flit(hi);
        recv_flit(lo);
        check_entry({hi, lo}, s.exp_entry);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        inject_val  = 1'b0;
        inject_data = '0;
        noc0_rdy    = 1'b0;
        rd_req_val  = 1'b0;
        rd_req_data = '0;
        rd_resp_rdy = 1'b0;
        cycle_count = 0;
        cycle_limit = CYCLE_MARGIN;
        void'($urandom(32'h0d8d_f5c9));
        model_seq   = '0;
        model_tail  = '0;
        build_table();
        cycle_limit = steps.size() * CYCLES_PER_STEP + CYCLE_MARGIN;

        @(posedge arst_n);
        foreach (steps[i]) begin
            if (steps[i].is_read) begin
                send_read(steps[i]);
            end else begin
                send_fwd(steps[i]);
            end
        end
        repeat (2) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
verilog/log_noc_pkg.sv
verilog/log_entry_pkg.sv
verilog/noc_narrow_to_wide.sv
verilog/noc_wide_to_narrow.sv
verilog/log_recorder.sv
verilog/log_ram.sv
verilog/log_read_engine.sv
verilog/tcp_log_replay.sv
verif/tb_clkgen.sv
verif/tb_tcp_log_replay.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_tcp_log_replay -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation run returned status $run_status"
    exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
